// File: hw/zip_dbg_config.svh
// Debug control block configuration: bus width, reset hold and command bit map
`ifndef ZIP_DBG_CONFIG_SVH
`define ZIP_DBG_CONFIG_SVH

// Debug port byte address width
`define ZD_ADDR_WIDTH 8

// Core reset cycles held after bus reset
`define ZD_RESET_DURATION 10

// Zero: core runs once reset hold ends
`define ZD_START_HALTED 0

// Command bits, same positions in the status word
`define ZD_RESET_BIT 6
`define ZD_STEP_BIT 8
`define ZD_HALT_BIT 10
`define ZD_CLEAR_CACHE_BIT 11

// Word address bit picking a core register over the control word
`define ZD_REG_SEL_BIT 5

`endif

// File: hw/zip_dbg_pkg.sv
// Shared debug-port vector types and command FSM state encoding
`include "zip_dbg_config.svh"

package zip_dbg_pkg;

	// One debug data word
	typedef logic [31:0] dbg_word_t;

	// Byte lane strobes for one word
	typedef logic [3:0] dbg_strb_t;

	// Word address, byte offset bits stripped
	typedef logic [`ZD_ADDR_WIDTH-3:0] dbg_waddr_t;

	// Index into the core register file
	typedef logic [4:0] dbg_reg_idx_t;

	// Core condition code flags
	typedef logic [2:0] dbg_cc_t;

	// Command FSM states
	typedef enum logic [2:0]
	{
		ST_RESET,
		ST_RUN,
		ST_HALTED,
		ST_STEP,
		ST_CLEAR
	} cmd_state_t;

endpackage

// File: hw/reset_hold_timer.sv
// Power-up timer holding the core in reset for a fixed count after bus reset
`include "zip_dbg_config.svh"

module reset_hold_timer #(
	parameter int DURATION = `ZD_RESET_DURATION
) (
	input  logic S_AXI_ACLK,
	input  logic S_AXI_ARESETN,
	output logic o_hold
);

	localparam int CW = $clog2(DURATION + 1);

	logic [CW-1:0] count;

	// Down-counter, parked at zero once done
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			count <= CW'(DURATION);
		else if (count != '0)
			count <= count - CW'(1);
	end

	// Registered copy, drops together with the last count
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_hold <= 1'b1;
		else
			o_hold <= (count > CW'(1));
	end

	// Flag and counter must agree every cycle
	a_hold_matches_count: assert property (@(posedge S_AXI_ACLK)
		o_hold == (count != '0));

endmodule

// File: hw/cpu_cmd_fsm.sv
// Command FSM driving core reset, halt, single step and cache clear levels
`include "zip_dbg_config.svh"

module cpu_cmd_fsm (
	input  logic                  S_AXI_ACLK,
	input  logic                  S_AXI_ARESETN,
	input  logic                  i_hold,
	input  logic                  i_cmd_wr,
	input  zip_dbg_pkg::dbg_word_t i_cmd_data,
	input  zip_dbg_pkg::dbg_strb_t i_cmd_strb,
	input  logic                  i_reg_wr,
	input  logic                  i_core_stall,
	input  logic                  i_core_break,
	output logic                  o_core_reset,
	output logic                  o_halt,
	output logic                  o_step,
	output logic                  o_clear_cache
);

	import zip_dbg_pkg::*;

	localparam bit START_HALTED = `ZD_START_HALTED;

	cmd_state_t state;
	cmd_state_t state_next;

	////////////////////////////////////////////////////////////////////////////
	// Next state
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		state_next = state;
		// Power-up hold wins over everything
		if (i_hold)
			state_next = ST_RESET;
		// Reset pulse is a single cycle
		else if (state == ST_RESET)
			state_next = START_HALTED ? ST_HALTED : ST_RUN;
		// Core exception
		else if (i_core_break)
			state_next = START_HALTED ? ST_HALTED : ST_RESET;
		else if (i_cmd_wr)
		begin
			// Reset lives in byte 0, the rest in byte 1
			if (i_cmd_strb[0] && i_cmd_data[`ZD_RESET_BIT])
				state_next = ST_RESET;
			else if (i_cmd_strb[1])
			begin
				if (i_cmd_data[`ZD_CLEAR_CACHE_BIT] && i_cmd_data[`ZD_HALT_BIT])
					state_next = ST_CLEAR;
				else if (i_cmd_data[`ZD_STEP_BIT])
					state_next = ST_STEP;
				else if (i_cmd_data[`ZD_HALT_BIT])
					state_next = ST_HALTED;
				else
					state_next = ST_RUN;
			end
		end
		// Register file access needs a stopped core
		else if (i_reg_wr)
			state_next = ST_HALTED;
		// Step or clear done once core stops stalling
		else if (((state == ST_STEP) || (state == ST_CLEAR)) && !i_core_stall)
			state_next = ST_HALTED;
	end

	////////////////////////////////////////////////////////////////////////////
	// State and output registers
	////////////////////////////////////////////////////////////////////////////

	// Outputs decoded from next state, so they line up with state
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			state         <= ST_RESET;
			o_core_reset  <= 1'b1;
			o_halt        <= 1'b0;
			o_step        <= 1'b0;
			o_clear_cache <= 1'b0;
		end
		else
		begin
			state         <= state_next;
			o_core_reset  <= (state_next == ST_RESET);
			o_halt        <= (state_next == ST_HALTED) || (state_next == ST_CLEAR);
			o_step        <= (state_next == ST_STEP);
			o_clear_cache <= (state_next == ST_CLEAR);
		end
	end

	// Core never asked to step while held in reset
	a_no_step_in_reset: assert property (@(posedge S_AXI_ACLK)
		disable iff (!S_AXI_ARESETN)
		!(o_core_reset && o_step));

endmodule

// File: hw/dbg_axil_write.sv
// AXI-lite debug write channel routing register writes to core, commands to FSM
`include "zip_dbg_config.svh"

module dbg_axil_write (
	input  logic                     S_AXI_ACLK,
	input  logic                     S_AXI_ARESETN,
	input  logic                     i_dbg_awvalid,
	input  zip_dbg_pkg::dbg_waddr_t   i_dbg_awaddr,
	input  logic                     i_dbg_wvalid,
	input  zip_dbg_pkg::dbg_word_t    i_dbg_wdata,
	input  zip_dbg_pkg::dbg_strb_t    i_dbg_wstrb,
	input  logic                     i_dbg_bready,
	input  logic                     i_core_stall,
	output logic                     o_dbg_awready,
	output logic                     o_dbg_wready,
	output logic                     o_dbg_bvalid,
	output logic                     o_core_we,
	output zip_dbg_pkg::dbg_reg_idx_t o_core_wreg,
	output zip_dbg_pkg::dbg_word_t    o_core_wdata,
	output logic                     o_cmd_wr,
	output zip_dbg_pkg::dbg_word_t    o_cmd_data,
	output zip_dbg_pkg::dbg_strb_t    o_cmd_strb,
	output logic                     o_reg_wr
);

	import zip_dbg_pkg::*;

	dbg_reg_idx_t wr_idx;
	logic         wr_is_cmd;
	logic         slot_free;
	logic         accept;

	assign wr_idx    = i_dbg_awaddr[4:0];
	assign wr_is_cmd = !i_dbg_awaddr[`ZD_REG_SEL_BIT];

	// Core takes the pending write when it stops stalling
	assign slot_free = !o_core_we || !i_core_stall;

	// Address and data together, B slot open, target able to take it
	assign accept = i_dbg_awvalid && i_dbg_wvalid
		&& (!o_dbg_bvalid || i_dbg_bready)
		&& (wr_is_cmd || (i_dbg_wstrb == '0) || slot_free);

	assign o_dbg_awready = accept;
	assign o_dbg_wready  = accept;

	// Command path, one-cycle strobe straight to FSM
	assign o_cmd_wr   = accept && wr_is_cmd;
	assign o_cmd_data = i_dbg_wdata;
	assign o_cmd_strb = i_dbg_wstrb;

	// Register writes also halt the core
	assign o_reg_wr = accept && !wr_is_cmd && (i_dbg_wstrb != '0);

	////////////////////////////////////////////////////////////////////////////
	// Core register write port
	////////////////////////////////////////////////////////////////////////////

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_core_we <= 1'b0;
		else if (slot_free)
			o_core_we <= o_reg_wr;
	end

	// Index and data frozen while core stalls
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (slot_free)
		begin
			o_core_wreg  <= wr_idx;
			o_core_wdata <= i_dbg_wdata;
		end
	end

	// Write response
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_dbg_bvalid <= 1'b0;
		else if (accept)
			o_dbg_bvalid <= 1'b1;
		else if (i_dbg_bready)
			o_dbg_bvalid <= 1'b0;
	end

	// Stalled core write holds its whole request
	a_core_write_stable: assert property (@(posedge S_AXI_ACLK)
		disable iff (!S_AXI_ARESETN)
		(o_core_we && i_core_stall)
		|=> ($stable(o_core_we) && $stable(o_core_wreg) && $stable(o_core_wdata)));

endmodule

// File: hw/dbg_axil_read.sv
// AXI-lite debug read channel returning a core register or the status word
`include "zip_dbg_config.svh"

module dbg_axil_read (
	input  logic                     S_AXI_ACLK,
	input  logic                     S_AXI_ARESETN,
	input  logic                     i_dbg_arvalid,
	input  zip_dbg_pkg::dbg_waddr_t   i_dbg_araddr,
	input  logic                     i_dbg_rready,
	input  zip_dbg_pkg::dbg_word_t    i_core_rdata,
	input  zip_dbg_pkg::dbg_cc_t      i_core_cc,
	input  logic                     i_core_stall,
	input  logic                     i_core_break,
	input  logic                     i_interrupt,
	input  logic                     i_core_reset,
	input  logic                     i_halt,
	input  logic                     i_step,
	input  logic                     i_clear_cache,
	output logic                     o_dbg_arready,
	output logic                     o_dbg_rvalid,
	output zip_dbg_pkg::dbg_word_t    o_dbg_rdata,
	output zip_dbg_pkg::dbg_reg_idx_t o_core_rreg
);

	import zip_dbg_pkg::*;

	dbg_word_t status;
	logic      rd_is_reg;
	logic      rd_pending;
	logic      accept;

	assign rd_is_reg = i_dbg_araddr[`ZD_REG_SEL_BIT];

	// One read in flight, R slot free or draining
	assign accept = i_dbg_arvalid && !rd_pending && (!o_dbg_rvalid || i_dbg_rready);

	assign o_dbg_arready = accept;

	// Core sees index now, answers next cycle
	assign o_core_rreg = i_dbg_araddr[4:0];

	////////////////////////////////////////////////////////////////////////////
	// Status word
	////////////////////////////////////////////////////////////////////////////

	always_comb
	begin
		status                      = '0;
		status[`ZD_RESET_BIT]       = i_core_reset;
		status[7]                   = i_interrupt;
		status[`ZD_STEP_BIT]        = i_step;
		status[9]                   = !i_core_stall;
		status[`ZD_HALT_BIT]        = i_halt;
		status[`ZD_CLEAR_CACHE_BIT] = i_clear_cache;
		status[14:12]               = i_core_cc;
		status[15]                  = i_core_break;
	end

	// Waiting on core register data
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			rd_pending <= 1'b0;
		else
			rd_pending <= accept && rd_is_reg;
	end

	// Status answers at once, core data one cycle later
	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
			o_dbg_rvalid <= 1'b0;
		else if (!o_dbg_rvalid || i_dbg_rready)
			o_dbg_rvalid <= (accept && !rd_is_reg) || rd_pending;
	end

	always_ff @(posedge S_AXI_ACLK)
	begin
		if (!o_dbg_rvalid || i_dbg_rready)
			o_dbg_rdata <= rd_pending ? i_core_rdata : status;
	end

	// Core read never overlaps a response still on the bus
	a_pending_xor_rvalid: assert property (@(posedge S_AXI_ACLK)
		disable iff (!S_AXI_ARESETN)
		!(rd_pending && o_dbg_rvalid));

endmodule

// File: hw/zip_dbg_ctrl.sv
// Debug control top: AXI-lite debug port to CPU core debug port
module zip_dbg_ctrl (
	input  logic                     S_AXI_ACLK,
	input  logic                     S_AXI_ARESETN,
	input  logic                     i_interrupt,
	// Debug write
	input  logic                     i_dbg_awvalid,
	output logic                     o_dbg_awready,
	input  zip_dbg_pkg::dbg_waddr_t   i_dbg_awaddr,
	input  logic                     i_dbg_wvalid,
	output logic                     o_dbg_wready,
	input  zip_dbg_pkg::dbg_word_t    i_dbg_wdata,
	input  zip_dbg_pkg::dbg_strb_t    i_dbg_wstrb,
	output logic                     o_dbg_bvalid,
	input  logic                     i_dbg_bready,
	// Debug read
	input  logic                     i_dbg_arvalid,
	output logic                     o_dbg_arready,
	input  zip_dbg_pkg::dbg_waddr_t   i_dbg_araddr,
	output logic                     o_dbg_rvalid,
	input  logic                     i_dbg_rready,
	output zip_dbg_pkg::dbg_word_t    o_dbg_rdata,
	// Core debug port
	output logic                     o_core_reset,
	output logic                     o_halt,
	output logic                     o_step,
	output logic                     o_clear_cache,
	output logic                     o_core_we,
	output zip_dbg_pkg::dbg_reg_idx_t o_core_wreg,
	output zip_dbg_pkg::dbg_word_t    o_core_wdata,
	output zip_dbg_pkg::dbg_reg_idx_t o_core_rreg,
	input  zip_dbg_pkg::dbg_word_t    i_core_rdata,
	input  zip_dbg_pkg::dbg_cc_t      i_core_cc,
	input  logic                     i_core_stall,
	input  logic                     i_core_break
);

	import zip_dbg_pkg::*;

	logic      hold;
	logic      cmd_wr;
	dbg_word_t cmd_data;
	dbg_strb_t cmd_strb;
	logic      reg_wr;

	////////////////////////////////////////////////////////////////////////////
	// Reset hold and command FSM
	////////////////////////////////////////////////////////////////////////////

	reset_hold_timer u_reset_hold_timer (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.o_hold        (hold)
	);

	cpu_cmd_fsm u_cpu_cmd_fsm (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_hold        (hold),
		.i_cmd_wr      (cmd_wr),
		.i_cmd_data    (cmd_data),
		.i_cmd_strb    (cmd_strb),
		.i_reg_wr      (reg_wr),
		.i_core_stall  (i_core_stall),
		.i_core_break  (i_core_break),
		.o_core_reset  (o_core_reset),
		.o_halt        (o_halt),
		.o_step        (o_step),
		.o_clear_cache (o_clear_cache)
	);

	////////////////////////////////////////////////////////////////////////////
	// Debug bus channels
	////////////////////////////////////////////////////////////////////////////

	dbg_axil_write u_dbg_axil_write (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_dbg_awvalid (i_dbg_awvalid),
		.i_dbg_awaddr  (i_dbg_awaddr),
		.i_dbg_wvalid  (i_dbg_wvalid),
		.i_dbg_wdata   (i_dbg_wdata),
		.i_dbg_wstrb   (i_dbg_wstrb),
		.i_dbg_bready  (i_dbg_bready),
		.i_core_stall  (i_core_stall),
		.o_dbg_awready (o_dbg_awready),
		.o_dbg_wready  (o_dbg_wready),
		.o_dbg_bvalid  (o_dbg_bvalid),
		.o_core_we     (o_core_we),
		.o_core_wreg   (o_core_wreg),
		.o_core_wdata  (o_core_wdata),
		.o_cmd_wr      (cmd_wr),
		.o_cmd_data    (cmd_data),
		.o_cmd_strb    (cmd_strb),
		.o_reg_wr      (reg_wr)
	);

	// Status fed back from FSM outputs
	dbg_axil_read u_dbg_axil_read (
		.S_AXI_ACLK    (S_AXI_ACLK),
		.S_AXI_ARESETN (S_AXI_ARESETN),
		.i_dbg_arvalid (i_dbg_arvalid),
		.i_dbg_araddr  (i_dbg_araddr),
		.i_dbg_rready  (i_dbg_rready),
		.i_core_rdata  (i_core_rdata),
		.i_core_cc     (i_core_cc),
		.i_core_stall  (i_core_stall),
		.i_core_break  (i_core_break),
		.i_interrupt   (i_interrupt),
		.i_core_reset  (o_core_reset),
		.i_halt        (o_halt),
		.i_step        (o_step),
		.i_clear_cache (o_clear_cache),
		.o_dbg_arready (o_dbg_arready),
		.o_dbg_rvalid  (o_dbg_rvalid),
		.o_dbg_rdata   (o_dbg_rdata),
		.o_core_rreg   (o_core_rreg)
	);

endmodule

// File: verif/tb_zip_dbg_ctrl.sv
// Testbench for the debug control block with a register file model of the core
`include "zip_dbg_config.svh"

module tb_zip_dbg_ctrl;

	import zip_dbg_pkg::*;

	localparam int CLK_PERIOD   = 20;
	localparam int RESET_CYCLES = 16;
	// Limit far above the length of the directed tests
	localparam int TIMEOUT_CYCLES = 2000;
	localparam dbg_waddr_t CMD_ADDR = '0;

	logic         S_AXI_ACLK;
	logic         S_AXI_ARESETN;
	logic         i_interrupt;
	logic         i_dbg_awvalid;
	logic         o_dbg_awready;
	dbg_waddr_t   i_dbg_awaddr;
	logic         i_dbg_wvalid;
	logic         o_dbg_wready;
	dbg_word_t    i_dbg_wdata;
	dbg_strb_t    i_dbg_wstrb;
	logic         o_dbg_bvalid;
	logic         i_dbg_bready;
	logic         i_dbg_arvalid;
	logic         o_dbg_arready;
	dbg_waddr_t   i_dbg_araddr;
	logic         o_dbg_rvalid;
	logic         i_dbg_rready;
	dbg_word_t    o_dbg_rdata;
	logic         o_core_reset;
	logic         o_halt;
	logic         o_step;
	logic         o_clear_cache;
	logic         o_core_we;
	dbg_reg_idx_t o_core_wreg;
	dbg_word_t    o_core_wdata;
	dbg_reg_idx_t o_core_rreg;
	dbg_word_t    i_core_rdata;
	dbg_cc_t      i_core_cc;
	logic         i_core_stall;
	logic         i_core_break;

	// Core model and checker state
	dbg_word_t    core_regs [32];
	dbg_word_t    exp_regs [32];
	dbg_reg_idx_t touched [$];
	dbg_reg_idx_t rd_idx;
	logic [31:0]  lfsr_state;
	int           cycle_count = 0;

	zip_dbg_ctrl i_zip_dbg_ctrl (.*);

	initial
	begin
		S_AXI_ACLK = 1'b0;
		forever
			#(CLK_PERIOD / 2) S_AXI_ACLK = ~S_AXI_ACLK;
	end

	////////////////////////////////////////////////////////////////////////////
	// Core model
	////////////////////////////////////////////////////////////////////////////

	// Register file filled from the whole index while in reset
	always @(posedge S_AXI_ACLK)
	begin
		if (!S_AXI_ARESETN)
		begin
			for (int i = 0; i < 32; i++)
				core_regs[i] <= 32'h5a00_0000 ^ (32'(i) * 32'h0001_0203);
		end
		else if (o_core_we && !i_core_stall)
			core_regs[o_core_wreg] <= o_core_wdata;
	end

	// Index taken on the rising edge, data out on the next falling edge
	initial
	begin
		i_core_rdata = '0;
		rd_idx       = '0;
		forever
		begin
			@(posedge S_AXI_ACLK);
			rd_idx = o_core_rreg;
			@(negedge S_AXI_ACLK);
			i_core_rdata = core_regs[rd_idx];
		end
	end

	always @(posedge S_AXI_ACLK)
	begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES)
		begin
			$display("Timeout: tests still running after %0d cycles", TIMEOUT_CYCLES);
			$display("FAIL: see errors above");
			$fatal(1, "Run stopped by timeout");
		end
	end

	////////////////////////////////////////////////////////////////////////////
	// Compare tasks and helpers
	////////////////////////////////////////////////////////////////////////////

	task automatic stop_on_error();
		$display("FAIL: see errors above");
		$fatal(1, "Stopped at first error");
	endtask

	task automatic check_word(input string what, input dbg_word_t got, input dbg_word_t exp);
		if (got !== exp)
		begin
			$display("[FAIL] %0t %s: got %h, expected %h", $time, what, got, exp);
			stop_on_error();
		end
	endtask

	task automatic check_idx(input string what, input dbg_reg_idx_t got,
		input dbg_reg_idx_t exp);
		if (got !== exp)
		begin
			$display("[FAIL] %0t %s: got %0d, expected %0d", $time, what, got, exp);
			stop_on_error();
		end
	endtask

	task automatic check_bit(input string what, input logic got, input logic exp);
		if (got !== exp)
		begin
			$display("[FAIL] %0t %s: got %b, expected %b", $time, what, got, exp);
			stop_on_error();
		end
	endtask

	// Fibonacci LFSR with taps 32 22 2 1
	function automatic logic lfsr_step();
		logic fb;
		fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
		lfsr_state = {lfsr_state[30:0], fb};
		return fb;
	endfunction

	// One step per bit taken
	function automatic dbg_word_t lfsr_word(input int nbits);
		dbg_word_t w;
		w = '0;
		for (int i = 0; i < nbits; i++)
			w = {w[30:0], lfsr_step()};
		return w;
	endfunction

	// Register select bit set above the index
	function automatic dbg_waddr_t reg_addr(input dbg_reg_idx_t idx);
		return {1'b1, idx};
	endfunction

	// Expected status word from the current core side inputs
	function automatic dbg_word_t exp_status(input logic rst, input logic stp,
		input logic hlt, input logic clr);
		dbg_word_t s;
		s         = '0;
		s[6]      = rst;
		s[7]      = i_interrupt;
		s[8]      = stp;
		s[9]      = !i_core_stall;
		s[10]     = hlt;
		s[11]     = clr;
		s[14:12]  = i_core_cc;
		s[15]     = i_core_break;
		return s;
	endfunction

	// Starts on a falling edge and returns on the one after acceptance
	task automatic axi_write(input dbg_waddr_t addr, input dbg_word_t data,
		input dbg_strb_t strb);
		logic taken;
		i_dbg_awaddr  = addr;
		i_dbg_wdata   = data;
		i_dbg_wstrb   = strb;
		i_dbg_awvalid = 1'b1;
		i_dbg_wvalid  = 1'b1;
		taken = 1'b0;
		while (!taken)
		begin
			// Combinational ready sampled in the middle of the low phase
			#(CLK_PERIOD / 4);
			taken = o_dbg_awready && o_dbg_wready;
			@(negedge S_AXI_ACLK);
		end
		i_dbg_awvalid = 1'b0;
		i_dbg_wvalid  = 1'b0;
		while (!o_dbg_bvalid)
			@(negedge S_AXI_ACLK);
	endtask

	// Address left in place for the core index check
	task automatic axi_read(input dbg_waddr_t addr, output dbg_word_t data);
		logic taken;
		i_dbg_araddr  = addr;
		i_dbg_arvalid = 1'b1;
		taken = 1'b0;
		while (!taken)
		begin
			#(CLK_PERIOD / 4);
			taken = o_dbg_arready;
			@(negedge S_AXI_ACLK);
		end
		i_dbg_arvalid = 1'b0;
		while (!o_dbg_rvalid)
			@(negedge S_AXI_ACLK);
		data = o_dbg_rdata;
	endtask

	task automatic count_reset_cycles(output int n);
		n = 0;
		while (o_core_reset)
		begin
			n++;
			@(negedge S_AXI_ACLK);
		end
	endtask

	////////////////////////////////////////////////////////////////////////////
	// Directed tests
	////////////////////////////////////////////////////////////////////////////

	task automatic reset_hold_release();
		dbg_word_t rd;
		int        n;
		// Values still under bus reset
		check_bit("bvalid in reset", o_dbg_bvalid, 1'b0);
		check_bit("rvalid in reset", o_dbg_rvalid, 1'b0);
		check_bit("core_we in reset", o_core_we, 1'b0);
		check_bit("core_reset in reset", o_core_reset, 1'b1);
		check_bit("halt in reset", o_halt, 1'b0);
		check_bit("step in reset", o_step, 1'b0);
		check_bit("clear_cache in reset", o_clear_cache, 1'b0);
		S_AXI_ARESETN = 1'b1;
		// Status taken in the first cycle out of bus reset
		axi_read(CMD_ADDR, rd);
		check_word("status in reset hold", rd, exp_status(1'b1, 1'b0, 1'b0, 1'b0));
		count_reset_cycles(n);
		check_word("core reset hold cycles", dbg_word_t'(n), dbg_word_t'(`ZD_RESET_DURATION));
		check_bit("halt after hold", o_halt, 1'b0);
		axi_read(CMD_ADDR, rd);
		check_word("status after hold", rd, exp_status(1'b0, 1'b0, 1'b0, 1'b0));
	endtask

	task automatic halt_and_release();
		dbg_word_t rd;
		i_interrupt = 1'b1;
		i_core_cc   = 3'b101;
		axi_write(CMD_ADDR, 32'h1 << `ZD_HALT_BIT, 4'b0010);
		check_bit("halt after halt command", o_halt, 1'b1);
		axi_read(CMD_ADDR, rd);
		check_word("status halted", rd, exp_status(1'b0, 1'b0, 1'b1, 1'b0));
		// Bit 9 tracks stall
		i_core_stall = 1'b1;
		axi_read(CMD_ADDR, rd);
		check_word("status halted and stalled", rd, exp_status(1'b0, 1'b0, 1'b1, 1'b0));
		i_core_stall = 1'b0;
		axi_write(CMD_ADDR, '0, 4'hf);
		check_bit("halt after release", o_halt, 1'b0);
		axi_read(CMD_ADDR, rd);
		check_word("status running", rd, exp_status(1'b0, 1'b0, 1'b0, 1'b0));
	endtask

	task automatic reg_write_under_stall();
		dbg_reg_idx_t idx;
		dbg_word_t    data;
		idx  = dbg_reg_idx_t'(lfsr_word(5));
		data = lfsr_word(32);
		exp_regs[idx] = data;
		touched.push_back(idx);
		i_core_stall = 1'b1;
		axi_write(reg_addr(idx), data, 4'hf);
		check_bit("halt after register write", o_halt, 1'b1);
		// Whole request frozen while stalled
		for (int i = 0; i < 3; i++)
		begin
			check_bit("core_we under stall", o_core_we, 1'b1);
			check_idx("core_wreg under stall", o_core_wreg, idx);
			check_word("core_wdata under stall", o_core_wdata, data);
			@(negedge S_AXI_ACLK);
		end
		i_core_stall = 1'b0;
		@(negedge S_AXI_ACLK);
		check_bit("core_we after stall", o_core_we, 1'b0);
	endtask

	task automatic reg_readback();
		dbg_reg_idx_t idx;
		dbg_word_t    data;
		dbg_word_t    rd;
		for (int i = 0; i < 4; i++)
		begin
			idx  = dbg_reg_idx_t'(lfsr_word(5));
			data = lfsr_word(32);
			exp_regs[idx] = data;
			touched.push_back(idx);
			axi_write(reg_addr(idx), data, 4'hf);
		end
		foreach (touched[i])
		begin
			axi_read(reg_addr(touched[i]), rd);
			check_idx("core_rreg", o_core_rreg, touched[i]);
			check_word("register readback", rd, exp_regs[touched[i]]);
		end
	endtask

	task automatic step_and_clear_cache();
		dbg_word_t rd;
		i_core_stall = 1'b1;
		axi_write(CMD_ADDR, 32'h1 << `ZD_STEP_BIT, 4'b0010);
		check_bit("step while stalled", o_step, 1'b1);
		check_bit("halt during step", o_halt, 1'b0);
		@(negedge S_AXI_ACLK);
		check_bit("step held under stall", o_step, 1'b1);
		axi_read(CMD_ADDR, rd);
		check_word("status during step", rd, exp_status(1'b0, 1'b1, 1'b0, 1'b0));
		i_core_stall = 1'b0;
		while (o_step)
			@(negedge S_AXI_ACLK);
		check_bit("halt after step", o_halt, 1'b1);
		// Clear cache needs halt in the same write
		i_core_stall = 1'b1;
		axi_write(CMD_ADDR, (32'h1 << `ZD_CLEAR_CACHE_BIT) | (32'h1 << `ZD_HALT_BIT), 4'b0010);
		check_bit("clear_cache while stalled", o_clear_cache, 1'b1);
		check_bit("halt during clear", o_halt, 1'b1);
		axi_read(CMD_ADDR, rd);
		check_word("status during clear", rd, exp_status(1'b0, 1'b0, 1'b1, 1'b1));
		i_core_stall = 1'b0;
		while (o_clear_cache)
			@(negedge S_AXI_ACLK);
		check_bit("halt after clear", o_halt, 1'b1);
		check_bit("step after clear", o_step, 1'b0);
	endtask

	task automatic break_and_reset_cmd();
		dbg_word_t rd;
		int        n;
		i_core_break = 1'b1;
		@(negedge S_AXI_ACLK);
		i_core_break = 1'b0;
		count_reset_cycles(n);
		check_word("core reset cycles after break", dbg_word_t'(n), 32'd1);
		check_bit("halt after break", o_halt, 1'b0);
		// Reset bit sits in byte 0
		axi_write(CMD_ADDR, 32'h1 << `ZD_RESET_BIT, 4'b0001);
		count_reset_cycles(n);
		check_word("core reset cycles after command", dbg_word_t'(n), 32'd1);
		check_bit("halt after reset command", o_halt, 1'b0);
		axi_read(CMD_ADDR, rd);
		check_word("status running after reset", rd, exp_status(1'b0, 1'b0, 1'b0, 1'b0));
	endtask

	initial
	begin
		S_AXI_ARESETN = 1'b0;
		i_interrupt   = 1'b0;
		i_dbg_awvalid = 1'b0;
		i_dbg_awaddr  = '0;
		i_dbg_wvalid  = 1'b0;
		i_dbg_wdata   = '0;
		i_dbg_wstrb   = '0;
		i_dbg_bready  = 1'b1;
		i_dbg_arvalid = 1'b0;
		i_dbg_araddr  = '0;
		i_dbg_rready  = 1'b1;
		i_core_cc     = '0;
		i_core_stall  = 1'b0;
		i_core_break  = 1'b0;
		lfsr_state    = 32'hd6ff;
		repeat (RESET_CYCLES)
			@(negedge S_AXI_ACLK);
		reset_hold_release();
		halt_and_release();
		reg_write_under_stall();
		reg_readback();
		step_and_clear_cache();
		break_and_reset_cmd();
		$display("PASS: all tests");
		$finish;
	end

endmodule

// File: list.f
+incdir+hw
hw/zip_dbg_pkg.sv
hw/reset_hold_timer.sv
hw/cpu_cmd_fsm.sv
hw/dbg_axil_write.sv
hw/dbg_axil_read.sv
hw/zip_dbg_ctrl.sv
verif/tb_zip_dbg_ctrl.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the debug control testbench with Verilator, then scan the log
rm -f sim.log
verilator --binary --timing --assert --top-module tb_zip_dbg_ctrl -f list.f \
	-o tb_zip_dbg_ctrl \
	&& { ./obj_dir/tb_zip_dbg_ctrl > sim.log 2>&1; cat sim.log; } \
	&& ! grep -q "FAIL: see errors above" sim.log \
	&& grep -q "PASS: all tests" sim.log \
	&& echo "Simulation passed" \
	|| { echo "Simulation failed"; exit 1; }
